// ==== hw/rib_pkg.sv ====
package rib_pkg;

    // ----------------------------------------
    // widths and address split
    // ----------------------------------------
    localparam int XLEN      = 32;
    localparam int SLV_IDX_W = 4;   // top address bits pick the slave
    localparam int OFFS_W    = 28;  // remaining bits go to the slave

    // ----------------------------------------
    // slave map
    // ----------------------------------------
    localparam logic [SLV_IDX_W-1:0] SLV_RAM0   = 4'd0;  // instr/data ram
    localparam logic [SLV_IDX_W-1:0] SLV_RAM1   = 4'd1;  // data ram
    localparam logic [SLV_IDX_W-1:0] SLV_PERIPH = 4'd2;  // gpio + timer
    localparam int NUM_SLV = 3;  // index 3..15 is unmapped

    localparam int RAM0_WORDS = 1024;
    localparam int RAM1_WORDS = 256;

    // ----------------------------------------
    // request types
    // ----------------------------------------
    typedef struct packed {
        logic [SLV_IDX_W-1:0] idx;
        logic [OFFS_W-1:0]    offs;
    } rib_addr_t;

    // masters see a flat word, the decoder sees index + offset
    typedef union packed {
        logic [XLEN-1:0] raw;
        rib_addr_t       f;
    } rib_addr_u;

    typedef struct packed {
        logic            req;
        logic            we;
        rib_addr_u       addr;
        logic [XLEN-1:0] wdata;
    } rib_mreq_t;

    typedef struct packed {
        logic            sel;
        logic            we;
        logic [XLEN-1:0] offs;   // offset, zero extended
        logic [XLEN-1:0] wdata;
    } rib_sreq_t;

endpackage

// ==== hw/periph_pkg.sv ====
package periph_pkg;

    // ----------------------------------------
    // register map, byte offsets
    // ----------------------------------------
    localparam logic [31:0] REG_GPIO_OUT = 32'h00;  // r/w, drives pins
    localparam logic [31:0] REG_GPIO_IN  = 32'h04;  // read only
    localparam logic [31:0] REG_TMR_CTRL = 32'h08;
    localparam logic [31:0] REG_TMR_CNT  = 32'h0C;  // read only
    localparam logic [31:0] REG_TMR_CMP  = 32'h10;

    // ----------------------------------------
    // timer control bits
    // ----------------------------------------
    // a write with the enable bit low stops and clears the counter
    localparam int CTRL_EN_BIT = 0;

    // write 1 to drop the sticky irq, reads back the irq state
    localparam int CTRL_IRQ_CLR_BIT = 1;

    // ----------------------------------------
    // gpio
    // ----------------------------------------
    localparam int GPIO_W = 8;

endpackage

// ==== hw/rib_ram.sv ====
module rib_ram #(
    parameter int WORDS = 256  // power of two, offsets wrap
) (
    input  logic                     clk,
    input  rib_pkg::rib_sreq_t       req_i,
    output logic [rib_pkg::XLEN-1:0] rdata_o
);

    // ----------------------------------------
    // storage
    // ----------------------------------------
    logic [rib_pkg::XLEN-1:0] mem [WORDS];
    logic [$clog2(WORDS)-1:0] widx;

    // word index, byte lane bits dropped
    assign widx = req_i.offs[2 +: $clog2(WORDS)];

    // ----------------------------------------
    // access port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (req_i.sel) begin
            if (req_i.we) begin
                mem[widx] <= req_i.wdata;
            end
            rdata_o <= mem[widx];  // old word on a write
        end
    end

endmodule

// ==== hw/rib_gpio_timer.sv ====
module rib_gpio_timer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  rib_pkg::rib_sreq_t               req_i,
    output logic [rib_pkg::XLEN-1:0]         rdata_o,
    input  logic [periph_pkg::GPIO_W-1:0]    gpio_i,
    output logic [periph_pkg::GPIO_W-1:0]    gpio_o,
    output logic                             irq_o
);

    logic [periph_pkg::GPIO_W-1:0] gpio_out_q;
    logic [periph_pkg::GPIO_W-1:0] gpio_in_q;
    logic                          tmr_en_q;
    logic [rib_pkg::XLEN-1:0]      tmr_cnt_q;
    logic [rib_pkg::XLEN-1:0]      tmr_cmp_q;
    logic                          irq_q;
    logic                          wr_en;
    logic                          wr_out;
    logic                          wr_ctrl;
    logic                          wr_cmp;
    logic                          tmr_hit;
    logic [rib_pkg::XLEN-1:0]      rd_mux;

    // ----------------------------------------
    // write decode
    // ----------------------------------------
    assign wr_en   = req_i.sel & req_i.we;
    assign wr_out  = wr_en && (req_i.offs == periph_pkg::REG_GPIO_OUT);
    assign wr_ctrl = wr_en && (req_i.offs == periph_pkg::REG_TMR_CTRL);
    assign wr_cmp  = wr_en && (req_i.offs == periph_pkg::REG_TMR_CMP);

    // ----------------------------------------
    // gpio
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
            gpio_in_q  <= '0;
        end else begin
            gpio_in_q <= gpio_i;  // one cycle late sample
            if (wr_out) begin
                gpio_out_q <= req_i.wdata[periph_pkg::GPIO_W-1:0];
            end
        end
    end

    assign gpio_o = gpio_out_q;

    // ----------------------------------------
    // compare timer
    // ----------------------------------------
    assign tmr_hit = tmr_en_q && (tmr_cnt_q == tmr_cmp_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmr_en_q  <= 1'b0;
            tmr_cnt_q <= '0;
            tmr_cmp_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            if (wr_cmp) begin
                tmr_cmp_q <= req_i.wdata;
            end
            if (wr_ctrl) begin
                tmr_en_q <= req_i.wdata[periph_pkg::CTRL_EN_BIT];
            end
            if (wr_ctrl && !req_i.wdata[periph_pkg::CTRL_EN_BIT]) begin
                tmr_cnt_q <= '0;  // stop and clear
            end else if (tmr_hit) begin
                tmr_cnt_q <= '0;
            end else if (tmr_en_q) begin
                tmr_cnt_q <= tmr_cnt_q + 1'b1;
            end
            // clear beats a match in the same cycle
            if (wr_ctrl && req_i.wdata[periph_pkg::CTRL_IRQ_CLR_BIT]) begin
                irq_q <= 1'b0;
            end else if (tmr_hit) begin
                irq_q <= 1'b1;  // sticky
            end
        end
    end

    assign irq_o = irq_q;

    // ----------------------------------------
    // read port
    // ----------------------------------------
    always_comb begin
        rd_mux = '0;
        case (req_i.offs)
            periph_pkg::REG_GPIO_OUT: rd_mux[periph_pkg::GPIO_W-1:0] = gpio_out_q;
            periph_pkg::REG_GPIO_IN:  rd_mux[periph_pkg::GPIO_W-1:0] = gpio_in_q;
            periph_pkg::REG_TMR_CTRL: begin
                rd_mux[periph_pkg::CTRL_EN_BIT]      = tmr_en_q;
                rd_mux[periph_pkg::CTRL_IRQ_CLR_BIT] = irq_q;  // pending flag
            end
            periph_pkg::REG_TMR_CNT:  rd_mux = tmr_cnt_q;
            periph_pkg::REG_TMR_CMP:  rd_mux = tmr_cmp_q;
            default:                  rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_i.sel) begin
            rdata_o <= rd_mux;
        end
    end

endmodule

// ==== hw/rib_bus.sv ====
module rib_bus (
    input  logic                                             clk,
    input  logic                                             rst_n,

    // full masters
    input  rib_pkg::rib_mreq_t                               m0_req_i,  // core data
    input  rib_pkg::rib_mreq_t                               m2_req_i,  // debug
    input  rib_pkg::rib_mreq_t                               m3_req_i,  // aux
    // fetch master, read only, always slave 0
    input  logic [rib_pkg::XLEN-1:0]                         m1_addr_i,

    output logic [rib_pkg::XLEN-1:0]                         m0_rdata_o,
    output logic [rib_pkg::XLEN-1:0]                         m1_rdata_o,
    output logic [rib_pkg::XLEN-1:0]                         m2_rdata_o,
    output logic [rib_pkg::XLEN-1:0]                         m3_rdata_o,

    output logic                                             m0_gnt_o,
    output logic                                             m2_gnt_o,
    output logic                                             m3_gnt_o,
    output logic                                             hold_o,    // stall fetch

    output rib_pkg::rib_sreq_t [rib_pkg::NUM_SLV-1:0]        s_req_o,
    input  logic [rib_pkg::NUM_SLV-1:0][rib_pkg::XLEN-1:0]   s_rdata_i
);

    rib_pkg::rib_mreq_t win;         // request of the granted master
    rib_pkg::rib_addr_u m1_addr;
    logic [rib_pkg::XLEN-1:0] win_offs;
    logic [rib_pkg::XLEN-1:0] fetch_offs;

    // per master, bit 0..3 = m0..m3
    logic [3:0]                                acc;      // served this cycle
    logic [3:0][rib_pkg::SLV_IDX_W-1:0]        acc_idx;  // slave it addressed
    logic [3:0]                                pend_q;   // read data arrives now
    logic [3:0][rib_pkg::SLV_IDX_W-1:0]        rsel_q;
    logic [3:0][rib_pkg::XLEN-1:0]             rdata_q;  // last value shown
    logic [3:0][rib_pkg::XLEN-1:0]             rdata;

    // ----------------------------------------
    // fixed priority arbiter, m3 > m0 > m2 > m1
    // ----------------------------------------
    assign m3_gnt_o = m3_req_i.req;
    assign m0_gnt_o = m0_req_i.req & ~m3_req_i.req;
    assign m2_gnt_o = m2_req_i.req & ~m3_req_i.req & ~m0_req_i.req;
    assign hold_o   = m3_req_i.req | m0_req_i.req | m2_req_i.req;

    always_comb begin
        if (m3_req_i.req) begin
            win = m3_req_i;
        end else if (m0_req_i.req) begin
            win = m0_req_i;
        end else begin
            win = m2_req_i;  // only used when m2 requests
        end
    end

    // ----------------------------------------
    // decode and routing to the slaves
    // ----------------------------------------
    assign m1_addr.raw = m1_addr_i;
    assign win_offs    = {{rib_pkg::SLV_IDX_W{1'b0}}, win.addr.f.offs};
    assign fetch_offs  = {{rib_pkg::SLV_IDX_W{1'b0}}, m1_addr.f.offs};

    always_comb begin
        for (int s = 0; s < rib_pkg::NUM_SLV; s++) begin
            s_req_o[s].sel   = hold_o && (int'(win.addr.f.idx) == s);
            s_req_o[s].we    = hold_o && (int'(win.addr.f.idx) == s) && win.we;
            s_req_o[s].offs  = win_offs;
            s_req_o[s].wdata = win.wdata;
        end
        // bus idle, fetch owns ram 0
        if (!hold_o) begin
            s_req_o[rib_pkg::SLV_RAM0].sel  = 1'b1;
            s_req_o[rib_pkg::SLV_RAM0].offs = fetch_offs;
        end
    end

    // ----------------------------------------
    // read return
    // ----------------------------------------
    assign acc = {m3_gnt_o, m2_gnt_o, ~hold_o, m0_gnt_o};

    assign acc_idx[0] = m0_req_i.addr.f.idx;
    assign acc_idx[1] = rib_pkg::SLV_RAM0;
    assign acc_idx[2] = m2_req_i.addr.f.idx;
    assign acc_idx[3] = m3_req_i.addr.f.idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q  <= '0;
            rsel_q  <= '0;
            rdata_q <= '0;
        end else begin
            pend_q  <= acc;
            rdata_q <= rdata;
            for (int m = 0; m < 4; m++) begin
                if (acc[m]) begin
                    rsel_q[m] <= acc_idx[m];
                end
            end
        end
    end

    // fresh slave data one cycle after the access, else hold the last word
    always_comb begin
        for (int m = 0; m < 4; m++) begin
            rdata[m] = rdata_q[m];
            if (pend_q[m]) begin
                rdata[m] = '0;  // unmapped slave reads zero
                if (int'(rsel_q[m]) < rib_pkg::NUM_SLV) begin
                    rdata[m] = s_rdata_i[rsel_q[m]];
                end
            end
        end
    end

    assign m0_rdata_o = rdata[0];
    assign m1_rdata_o = rdata[1];
    assign m2_rdata_o = rdata[2];
    assign m3_rdata_o = rdata[3];

endmodule

// ==== hw/rib_soc_top.sv ====
module rib_soc_top (
    input  logic                             clk,
    input  logic                             rst_n,

    // masters
    input  rib_pkg::rib_mreq_t               m0_req_i,
    input  logic [rib_pkg::XLEN-1:0]         m1_addr_i,
    input  rib_pkg::rib_mreq_t               m2_req_i,
    input  rib_pkg::rib_mreq_t               m3_req_i,

    output logic [rib_pkg::XLEN-1:0]         m0_rdata_o,
    output logic [rib_pkg::XLEN-1:0]         m1_rdata_o,
    output logic [rib_pkg::XLEN-1:0]         m2_rdata_o,
    output logic [rib_pkg::XLEN-1:0]         m3_rdata_o,

    output logic                             m0_gnt_o,
    output logic                             m2_gnt_o,
    output logic                             m3_gnt_o,
    output logic                             hold_o,

    // pins
    input  logic [periph_pkg::GPIO_W-1:0]    gpio_i,
    output logic [periph_pkg::GPIO_W-1:0]    gpio_o,
    output logic                             timer_irq_o
);

    // ----------------------------------------
    // slave side of the bus
    // ----------------------------------------
    rib_pkg::rib_sreq_t [rib_pkg::NUM_SLV-1:0]        s_req;
    logic [rib_pkg::NUM_SLV-1:0][rib_pkg::XLEN-1:0]   s_rdata;

    rib_bus i_bus (
        .clk        (clk),
        .rst_n      (rst_n),
        .m0_req_i   (m0_req_i),
        .m2_req_i   (m2_req_i),
        .m3_req_i   (m3_req_i),
        .m1_addr_i  (m1_addr_i),
        .m0_rdata_o (m0_rdata_o),
        .m1_rdata_o (m1_rdata_o),
        .m2_rdata_o (m2_rdata_o),
        .m3_rdata_o (m3_rdata_o),
        .m0_gnt_o   (m0_gnt_o),
        .m2_gnt_o   (m2_gnt_o),
        .m3_gnt_o   (m3_gnt_o),
        .hold_o     (hold_o),
        .s_req_o    (s_req),
        .s_rdata_i  (s_rdata)
    );

    // ----------------------------------------
    // slaves
    // ----------------------------------------
    rib_ram #(.WORDS(rib_pkg::RAM0_WORDS)) i_ram0 (  // shared with fetch
        .clk     (clk),
        .req_i   (s_req[rib_pkg::SLV_RAM0]),
        .rdata_o (s_rdata[rib_pkg::SLV_RAM0])
    );

    rib_ram #(.WORDS(rib_pkg::RAM1_WORDS)) i_ram1 (
        .clk     (clk),
        .req_i   (s_req[rib_pkg::SLV_RAM1]),
        .rdata_o (s_rdata[rib_pkg::SLV_RAM1])
    );

    rib_gpio_timer i_periph (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (s_req[rib_pkg::SLV_PERIPH]),
        .rdata_o (s_rdata[rib_pkg::SLV_PERIPH]),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o),
        .irq_o   (timer_irq_o)
    );

endmodule

// ==== tb/rib_bus_properties.sv ====
module rib_bus_properties (
    input logic               clk,
    input logic               rst_n,
    input rib_pkg::rib_mreq_t m0_req_i,
    input rib_pkg::rib_mreq_t m2_req_i,
    input rib_pkg::rib_mreq_t m3_req_i,
    input logic               m0_gnt_o,
    input logic               m2_gnt_o,
    input logic               m3_gnt_o,
    input logic               hold_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------
    // arbitration
    // ----------------------------------------
    a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({m0_gnt_o, m2_gnt_o, m3_gnt_o}))
        else $error("more than one grant in the same cycle");

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        hold_o == (m0_req_i.req | m2_req_i.req | m3_req_i.req))
        else $error("hold_o does not follow the requests");

    a_m3_first: assert property (@(posedge clk) disable iff (!rst_n)
        m3_req_i.req |-> m3_gnt_o)
        else $error("m3 requested but was not granted");

    a_m0_next: assert property (@(posedge clk) disable iff (!rst_n)
        (m0_req_i.req && !m3_req_i.req) |-> m0_gnt_o)
        else $error("m0 was top requester but was not granted");

    a_m2_last: assert property (@(posedge clk) disable iff (!rst_n)
        (m2_req_i.req && !m3_req_i.req && !m0_req_i.req) |-> m2_gnt_o)
        else $error("m2 was top requester but was not granted");

endmodule

// ==== tb/rib_soc_tb.sv ====
module rib_soc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int T1_N = 200;  // single master ram accesses
    localparam int T2_N = 60;   // rounds of up to three requests
    localparam int T3_N = 100;  // fetches
    localparam int T4_N = 16;
    localparam int T5_N = 4;
    localparam int T6_N = 40;
    localparam int TXN_TOTAL = T1_N + 3 * T2_N + T3_N + 5 * T4_N + 8 * T5_N + 2 * T6_N;
    localparam int WDOG_CYCLES = TXN_TOTAL * 20 + 4;

    logic clk;
    logic rst_n;
    rib_pkg::rib_mreq_t m0_req;
    rib_pkg::rib_mreq_t m2_req;
    rib_pkg::rib_mreq_t m3_req;
    logic [31:0] m1_addr;
    wire [3:0][31:0] rdata_w;
    wire [3:0] gnt_w;
    wire hold;
    logic [periph_pkg::GPIO_W-1:0] gpio_i_w;
    wire [periph_pkg::GPIO_W-1:0] gpio_o_w;
    wire irq;

    // model state
    logic [31:0] ram0_m [rib_pkg::RAM0_WORDS];
    logic [31:0] ram1_m [rib_pkg::RAM1_WORDS];
    bit known0 [rib_pkg::RAM0_WORDS];
    bit known1 [rib_pkg::RAM1_WORDS];
    logic [periph_pkg::GPIO_W-1:0] gpio_out_m = '0;
    logic [periph_pkg::GPIO_W-1:0] gpio_in_m = '0;
    logic [periph_pkg::GPIO_W-1:0] gpio_drv = '0;
    logic [31:0] cmp_m = '0;

    rib_pkg::rib_mreq_t rq [4];  // pending request per master (slot 1 unused)
    logic [31:0] fetch_addr = '0;
    logic [31:0] exp_val [4];
    logic [3:0] exp_known = '0;
    logic [3:0] exp_vld = '0;
    logic [31:0] m1_last = '0;
    logic hold_prev = 1'b0;
    int seed = 32'h31c4_088b;
    int test_err = 0;
    int err_total = 0;
    int n_tests = 0;
    int n_bad = 0;

    assign gnt_w[1] = 1'b0;

    rib_soc_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .m0_req_i(m0_req), .m1_addr_i(m1_addr), .m2_req_i(m2_req), .m3_req_i(m3_req),
        .m0_rdata_o(rdata_w[0]), .m1_rdata_o(rdata_w[1]),
        .m2_rdata_o(rdata_w[2]), .m3_rdata_o(rdata_w[3]),
        .m0_gnt_o(gnt_w[0]), .m2_gnt_o(gnt_w[2]), .m3_gnt_o(gnt_w[3]), .hold_o(hold),
        .gpio_i(gpio_i_w), .gpio_o(gpio_o_w), .timer_irq_o(irq)
    );

    bind rib_bus rib_bus_properties i_props (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    // ----------------------------------------
    // checks and reference model
    // ----------------------------------------
    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            test_err++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, test_err);
        n_tests++;
        if (test_err != 0) n_bad++;
        err_total += test_err;
        test_err = 0;
    endtask

    // a write returns the old value before it is applied
    task automatic model_access(input rib_pkg::rib_mreq_t r, output logic [31:0] v,
                                output logic k);
        logic [31:0] offs;
        int wi;
        offs = {4'h0, r.addr.f.offs};
        v = '0;
        k = 1'b1;
        case (r.addr.f.idx)
            rib_pkg::SLV_RAM0: begin
                wi = (offs >> 2) % rib_pkg::RAM0_WORDS;  // wraps
                v = ram0_m[wi];
                k = known0[wi];
                if (r.we) begin
                    ram0_m[wi] = r.wdata;
                    known0[wi] = 1'b1;
                end
            end
            rib_pkg::SLV_RAM1: begin
                wi = (offs >> 2) % rib_pkg::RAM1_WORDS;
                v = ram1_m[wi];
                k = known1[wi];
                if (r.we) begin
                    ram1_m[wi] = r.wdata;
                    known1[wi] = 1'b1;
                end
            end
            rib_pkg::SLV_PERIPH: begin
                if (offs == periph_pkg::REG_GPIO_OUT) v = 32'(gpio_out_m);
                else if (offs == periph_pkg::REG_GPIO_IN) v = 32'(gpio_in_m);
                else if (offs == periph_pkg::REG_TMR_CMP) v = cmp_m;
                else if (offs == periph_pkg::REG_TMR_CTRL || offs == periph_pkg::REG_TMR_CNT)
                    k = 1'b0;  // timer state not tracked here
                if (r.we && offs == periph_pkg::REG_GPIO_OUT) gpio_out_m = r.wdata[7:0];
                if (r.we && offs == periph_pkg::REG_TMR_CMP) cmp_m = r.wdata;
            end
            default: ;  // unmapped index reads zero and drops writes
        endcase
    endtask

    function automatic int winner();
        if (rq[3].req) return 3;
        if (rq[0].req) return 0;
        if (rq[2].req) return 2;
        return -1;
    endfunction

    // one bus cycle from falling edge to falling edge
    task automatic cycle();
        int w;
        logic k;
        rib_pkg::rib_mreq_t fr;
        @(negedge clk);
        for (int m = 0; m < 4; m++) begin
            if (exp_vld[m] && exp_known[m])
                compare($sformatf("m%0d_rdata_o", m), exp_val[m], rdata_w[m]);
        end
        if (hold_prev) compare("m1_rdata_o", m1_last, rdata_w[1]);  // stalled fetch
        compare("gpio_o", 32'(gpio_out_m), 32'(gpio_o_w));
        m1_last = rdata_w[1];
        exp_vld = '0;
        m0_req = rq[0];
        m2_req = rq[2];
        m3_req = rq[3];
        m1_addr = fetch_addr;
        gpio_i_w = gpio_drv;
        #1;
        w = winner();
        compare("hold_o", 32'(w >= 0), 32'(hold));
        compare("m0_gnt_o", 32'(w == 0), 32'(gnt_w[0]));
        compare("m2_gnt_o", 32'(w == 2), 32'(gnt_w[2]));
        compare("m3_gnt_o", 32'(w == 3), 32'(gnt_w[3]));
        if (w >= 0) begin
            model_access(rq[w], exp_val[w], k);
            rq[w].req = 1'b0;
        end else begin
            w = 1;
            fr = '0;
            fr.addr.raw = {4'h0, fetch_addr[27:0]};  // fetch always hits ram 0
            model_access(fr, exp_val[1], k);
        end
        exp_known[w] = k;
        exp_vld[w] = 1'b1;
        hold_prev = (w != 1);
    endtask

    task automatic load(input int m, input logic we, input logic [31:0] a, input logic [31:0] d);
        rq[m].req = 1'b1;
        rq[m].we = we;
        rq[m].addr.raw = a;
        rq[m].wdata = d;
    endtask

    task automatic serve();
        for (int n = 0; n < 8 && (rq[0].req || rq[2].req || rq[3].req); n++) cycle();
        if (rq[0].req || rq[2].req || rq[3].req) begin
            $display("error at %0t: a pending request was never granted", $time);
            test_err++;
            rq[0].req = 1'b0;
            rq[2].req = 1'b0;
            rq[3].req = 1'b0;
        end
    endtask

    task automatic access(input int m, input logic we, input logic [31:0] a,
                          input logic [31:0] d);
        load(m, we, a, d);
        serve();
    endtask

    function automatic logic [31:0] ram_addr(input logic [3:0] idx, input int words);
        int w;
        w = ($random(seed) & 15) + words * ($random(seed) & 3);  // upper copies alias
        return {idx, 28'(w * 4)};
    endfunction

    function automatic logic [31:0] periph_addr(input logic [31:0] offs);
        return {rib_pkg::SLV_PERIPH, offs[27:0]};
    endfunction

    function automatic int rand_master();
        case ($unsigned($random(seed)) % 3)
            0: return 0;
            1: return 2;
            default: return 3;
        endcase
    endfunction

    function automatic logic [31:0] rand_ram();
        logic [3:0] idx;
        idx = $random(seed) & 1;
        return ram_addr(idx, idx ? rib_pkg::RAM1_WORDS : rib_pkg::RAM0_WORDS);
    endfunction

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        int n;
        logic [31:0] a;
        rst_n = 1'b0;
        m0_req = '0;
        m2_req = '0;
        m3_req = '0;
        m1_addr = '0;
        gpio_i_w = '0;
        for (int i = 0; i < 4; i++) rq[i] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < T1_N; i++) begin
            access(rand_master(), $random(seed), rand_ram(), $random(seed));
        end
        cycle();
        end_test("ram_single");

        for (int i = 0; i < T2_N; i++) begin
            if ($random(seed) & 1) load(0, $random(seed), rand_ram(), $random(seed));
            if ($random(seed) & 1) load(2, $random(seed), rand_ram(), $random(seed));
            if ($random(seed) & 1) load(3, $random(seed), rand_ram(), $random(seed));
            serve();
        end
        cycle();
        end_test("priority");

        for (int i = 0; i < T3_N; i++) begin
            fetch_addr = ram_addr(4'h0, rib_pkg::RAM0_WORDS);
            if (i % 8 == 7) load(2, 1'b0, rand_ram(), '0);  // brief stall
            cycle();
        end
        cycle();
        end_test("fetch");

        for (int i = 0; i < T4_N; i++) begin
            gpio_drv = $random(seed);
            cycle();
            cycle();
            gpio_in_m = gpio_drv;  // settled for two cycles
            access(2, 1'b1, periph_addr(periph_pkg::REG_GPIO_OUT), $random(seed));
            access(0, 1'b0, periph_addr(periph_pkg::REG_GPIO_OUT), '0);
            access(3, 1'b0, periph_addr(periph_pkg::REG_GPIO_IN), '0);
        end
        cycle();
        end_test("gpio");

        for (int i = 0; i < T5_N; i++) begin
            n = $random(seed) & 63;
            access(0, 1'b1, periph_addr(periph_pkg::REG_TMR_CTRL),
                   32'h1 << periph_pkg::CTRL_IRQ_CLR_BIT);
            access(0, 1'b1, periph_addr(periph_pkg::REG_TMR_CMP), n);
            access(0, 1'b1, periph_addr(periph_pkg::REG_TMR_CTRL),
                   32'h1 << periph_pkg::CTRL_EN_BIT);
            for (int c = 1; c <= n + 3; c++) begin
                cycle();
                compare("timer_irq_o", 32'(c >= n + 2), 32'(irq));
            end
            access(3, 1'b1, periph_addr(periph_pkg::REG_TMR_CTRL),
                   32'h1 << periph_pkg::CTRL_IRQ_CLR_BIT);  // stop and clear
            cycle();
            compare("timer_irq_o", '0, 32'(irq));
        end
        end_test("timer");

        for (int i = 0; i < T6_N; i++) begin
            a = $random(seed);
            if (a[31:28] < 3) a[31:28] = 4'd3 + a[29:28];
            a[27:0] = 28'(($random(seed) & 15) * 4);  // offsets the readback covers
            access(rand_master(), $random(seed), a, $random(seed));
        end
        for (int w = 0; w < 16; w++) begin
            access(0, 1'b0, {rib_pkg::SLV_RAM0, 28'(w * 4)}, '0);
            access(2, 1'b0, {rib_pkg::SLV_RAM1, 28'(w * 4)}, '0);
        end
        access(3, 1'b0, periph_addr(periph_pkg::REG_GPIO_OUT), '0);
        access(3, 1'b0, periph_addr(periph_pkg::REG_TMR_CMP), '0);
        cycle();
        end_test("unmapped");

        $display("summary: %0d tests run, %0d with errors, %0d errors in total",
                 n_tests, n_bad, err_total);
        if (err_total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/rib_pkg.sv
hw/periph_pkg.sv
hw/rib_ram.sv
hw/rib_gpio_timer.sv
hw/rib_bus.sv
hw/rib_soc_top.sv
tb/rib_bus_properties.sv
tb/rib_soc_tb.sv
